//--- src.f
source/flowMuxPkg.sv
source/lruArbiter.sv
source/muxDatapath.sv
source/flowMuxLruStable.sv
sim/clockGen.sv
sim/flowMuxTb.sv

//--- Makefile
# Verilator build and run for the LRU flow mux testbench

VERILATOR  ?= verilator
TOP        ?= flowMuxTb
RTL_TOP    ?= flowMuxLruStable
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= All tests passed
RTL_SRCS   ?= source/flowMuxPkg.sv source/lruArbiter.sv source/muxDatapath.sv \
              source/flowMuxLruStable.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/flowMuxTb.sv
// Testbench for the LRU flow mux with a reference LRU model and scoreboard
`timescale 1ns/1ps

module flowMuxTb;

  // ------------------------------
  // Run lengths
  // ------------------------------

  localparam int T1Cycles = 20;
  localparam int T2Cycles = 24;
  localparam int T3Cycles = 60;
  localparam int T4Cycles = 32;
  localparam int T5Cycles = 400;
  localparam int DrainLimit = 50;
  localparam int TotalCycles = 6 + T1Cycles + T2Cycles + T3Cycles + T4Cycles + T5Cycles
                               + 5 * DrainLimit;
  // Twice the planned run at 10 ns per cycle
  localparam int WatchdogNs = TotalCycles * 10 * 2;

  // Request shapes for the irregular pattern test
  localparam flowMuxPkg::flowMask_t Patterns [8] = '{
    4'b0001, 4'b0110, 4'b1010, 4'b0100, 4'b1001, 4'b0000, 4'b1100, 4'b0011
  };

  logic clk;
  logic rst;

  flowMuxPkg::flowMask_t pushValid;
  logic [flowMuxPkg::NumFlows-1:0][flowMuxPkg::DataWidth-1:0] pushData;
  flowMuxPkg::flowMask_t pushReady;
  logic                  popReady;
  logic                  popValid;
  flowMuxPkg::popItem_t  popItem;

  // Reference state
  int                    modelOrder [flowMuxPkg::NumFlows];  // Index 0 is highest priority
  logic                  modelValid;
  flowMuxPkg::popItem_t  scoreQ [$];
  flowMuxPkg::flowMask_t acceptedMask;  // Handshakes seen at the last rising edge
  flowMuxPkg::flowMask_t lastAccept;

  // Counters
  int errorCount = 0;
  int checkCount = 0;
  int pushCount = 0;
  int popCount = 0;
  int failedTests = 0;
  int testErrorBase;
  int testPushBase;
  int testPopBase;

  clockGen clockSource (
    .clk,
    .rst
  );

  flowMuxLruStable UUT (
    .clk,
    .rst,
    .pushValid,
    .pushData,
    .pushReady,
    .popReady,
    .popValid,
    .popItem
  );

  // ------------------------------
  // Model helpers
  // ------------------------------

  // First valid flow in LRU order wins, -1 when nobody asks
  function automatic int expectedWinner(input int order [flowMuxPkg::NumFlows],
                                        input flowMuxPkg::flowMask_t valid);
    for (int p = 0; p < flowMuxPkg::NumFlows; p++) begin
      if (valid[order[p]]) begin
        return order[p];
      end
    end
    return -1;
  endfunction

  // Granted flow becomes least recent, the rest close ranks
  task automatic moveToBack(input int flow);
    int pos;
    pos = 0;
    for (int p = 0; p < flowMuxPkg::NumFlows; p++) begin
      if (modelOrder[p] == flow) begin
        pos = p;
      end
    end
    for (int p = pos; p < flowMuxPkg::NumFlows - 1; p++) begin
      modelOrder[p] = modelOrder[p + 1];
    end
    modelOrder[flowMuxPkg::NumFlows - 1] = flow;
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    end
  endtask

  // ------------------------------
  // Comparing process
  // ------------------------------

  always @(posedge clk) begin : compareProc
    int                    winner;
    logic                  expCanGrant;
    flowMuxPkg::flowMask_t expReady;
    flowMuxPkg::popItem_t  expItem;
    if (rst) begin
      for (int p = 0; p < flowMuxPkg::NumFlows; p++) begin
        modelOrder[p] = p;
      end
      modelValid = 1'b0;
      scoreQ.delete();
      acceptedMask = '0;
    end else begin
      // Output stage, one cycle behind the accept
      checkValue("popValid", 32'(modelValid), 32'(popValid));
      if (popValid) begin
        if (scoreQ.size() == 0) begin
          errorCount++;
          $display("At %0t ns the DUT shows an item although no word is outstanding", $time);
        end else begin
          checkValue("popItem", 32'(scoreQ[0]), 32'(popItem));
        end
      end

      // Room in the output register
      expCanGrant = !popValid || popReady;
      winner = expectedWinner(modelOrder, pushValid);
      expReady = '0;
      if (expCanGrant && winner >= 0) begin
        expReady[winner] = 1'b1;
      end
      checkValue("pushReady", 32'(expReady), 32'(pushReady));
      acceptedMask = pushValid & pushReady;

      if (popValid && popReady && scoreQ.size() > 0) begin
        void'(scoreQ.pop_front());
        popCount++;
      end

      if (expReady != '0) begin
        expItem.data = pushData[winner];
        expItem.flowIdx = flowMuxPkg::FlowIdxWidth'(winner);
        scoreQ.push_back(expItem);
        pushCount++;
        moveToBack(winner);
      end

      // Refill beats pop, like a one-entry buffer
      if (expReady != '0) begin
        modelValid = 1'b1;
      end else if (popReady) begin
        modelValid = 1'b0;
      end
    end
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  // Pending words stay put, idle flows in raiseMask get a new word
  task automatic stepCycle(input flowMuxPkg::flowMask_t raiseMask, input logic readyVal);
    flowMuxPkg::flowMask_t nextValid;
    @(negedge clk);
    lastAccept = acceptedMask;
    nextValid = pushValid & ~acceptedMask;
    for (int i = 0; i < flowMuxPkg::NumFlows; i++) begin
      if (!nextValid[i] && raiseMask[i]) begin
        nextValid[i] = 1'b1;
        pushData[i] = flowMuxPkg::DataWidth'($urandom());
      end
    end
    pushValid = nextValid;
    popReady = readyVal;
  endtask

  task automatic startTest;
    testErrorBase = errorCount;
    testPushBase = pushCount;
    testPopBase = popCount;
  endtask

  // Drain every pending word, then report the test
  task automatic finishTest(input int num, input string name);
    int waited;
    int testErrors;
    waited = 0;
    while ((pushValid != '0 || popValid) && waited < DrainLimit) begin
      stepCycle('0, 1'b1);
      waited++;
    end
    if (pushValid != '0 || popValid) begin
      errorCount++;
      $display("Test %0d did not drain within %0d cycles", num, DrainLimit);
    end
    checkValue("words popped", 32'(pushCount - testPushBase), 32'(popCount - testPopBase));
    testErrors = errorCount - testErrorBase;
    if (testErrors != 0) begin
      failedTests++;
    end
    $display("Test %0d %s: %0d words, %0d errors", num, name,
             popCount - testPopBase, testErrors);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------

  initial begin : mainProc
    int   accepts;
    int   stallLeft;
    logic readyNow;
    void'($urandom(32'h730a_0bc1));
    pushValid = '0;
    pushData = '0;
    popReady = 1'b0;
    lastAccept = '0;
    @(negedge rst);

    // Flow 3 alone keeps the reset order intact for the next test
    startTest();
    accepts = 0;
    for (int c = 0; c < T1Cycles; c++) begin
      stepCycle(4'b1000, 1'b1);
      // From the second cycle on, flow 3 transfers on every edge
      if (c > 0) begin
        checkValue("flow 3 accept", 32'(4'b1000), 32'(lastAccept));
      end
      if (lastAccept != '0) begin
        accepts++;
      end
    end
    checkValue("single flow accepts", 32'(T1Cycles - 1), 32'(accepts));
    finishTest(1, "single flow");

    // Round robin falls out of the LRU rule
    startTest();
    accepts = 0;
    for (int c = 0; c < T2Cycles; c++) begin
      stepCycle('1, 1'b1);
      if (lastAccept != '0) begin
        checkValue("grant order", 32'(1 << (accepts % flowMuxPkg::NumFlows)), 32'(lastAccept));
        accepts++;
      end
    end
    checkValue("all flow accepts", 32'(T2Cycles - 1), 32'(accepts));
    finishTest(2, "all flows");

    // Alternate stall and run stretches of random length
    startTest();
    readyNow = 1'b1;
    stallLeft = 0;
    for (int c = 0; c < T3Cycles; c++) begin
      if (stallLeft == 0) begin
        readyNow = !readyNow;
        stallLeft = readyNow ? 1 + int'($urandom() % 3) : 1 + int'($urandom() % 6);
      end
      stallLeft--;
      stepCycle('1, readyNow);
    end
    finishTest(3, "back-pressure");

    // Fixed request shapes, idle flows should keep their rank
    startTest();
    for (int c = 0; c < T4Cycles; c++) begin
      stepCycle(Patterns[c % 8], 1'b1);
    end
    finishTest(4, "irregular requests");

    startTest();
    for (int c = 0; c < T5Cycles; c++) begin
      stepCycle(flowMuxPkg::NumFlows'($urandom()), ($urandom() % 4) != 0);
    end
    finishTest(5, "random traffic");

    $display("Tests run: 5, failed: %0d, checks: %0d, errors: %0d",
             failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // ------------------------------
  // Watchdog
  // ------------------------------

  initial begin : watchdogProc
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the run did not finish", WatchdogNs);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- sim/clockGen.sv
// Testbench clock source with a 10 ns period and a 5-cycle reset
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  // Half of the 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset spans 5 rising edges and drops on a falling edge
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- source/flowMuxLruStable.sv
// Flow-controlled stable mux that merges producer flows with LRU arbitration
`timescale 1ns/1ps

module flowMuxLruStable (
  input  logic                  clk,
  input  logic                  rst,

  // Producer flows
  input  flowMuxPkg::flowMask_t pushValid,
  input  logic [flowMuxPkg::NumFlows-1:0][flowMuxPkg::DataWidth-1:0] pushData,
  output flowMuxPkg::flowMask_t pushReady,

  // Consumer flow
  input  logic                  popReady,
  output logic                  popValid,
  output flowMuxPkg::popItem_t  popItem
);

  // ------------------------------
  // Arbiter to datapath wiring
  // ------------------------------

  flowMuxPkg::flowMask_t request;
  flowMuxPkg::flowMask_t grant;
  logic                  canGrant;
  logic                  enablePriorityUpdate;

  // Holds the LRU order and picks the winner
  lruArbiter arbiter (
    .clk,
    .rst,
    .request,
    .canGrant,
    .grant,
    .enablePriorityUpdate
  );

  // Steers the granted word into the output register
  muxDatapath datapath (
    .clk,
    .rst,
    .pushValid,
    .pushData,
    .pushReady,
    .popReady,
    .popValid,
    .popItem,
    .request,
    .canGrant,
    .grant,
    .enablePriorityUpdate
  );

endmodule

//--- source/muxDatapath.sv
// Mux datapath with word selection, stable output register and push/pop handshakes
`timescale 1ns/1ps

module muxDatapath (
  input  logic                  clk,
  input  logic                  rst,

  // Push side, one word per flow
  input  flowMuxPkg::flowMask_t pushValid,
  input  logic [flowMuxPkg::NumFlows-1:0][flowMuxPkg::DataWidth-1:0] pushData,
  output flowMuxPkg::flowMask_t pushReady,

  // Pop side
  input  logic                  popReady,
  output logic                  popValid,
  output flowMuxPkg::popItem_t  popItem,

  // Arbiter side
  output flowMuxPkg::flowMask_t request,
  output logic                  canGrant,
  input  flowMuxPkg::flowMask_t grant,
  output logic                  enablePriorityUpdate
);

  // ------------------------------
  // Handshake glue
  // ------------------------------

  // A word transfers on some flow this cycle
  logic pushAccept;

  // Granted word and its source index
  logic [flowMuxPkg::DataWidth-1:0]    selData;
  logic [flowMuxPkg::FlowIdxWidth-1:0] selIdx;
  flowMuxPkg::popItem_t                nextItem;

  // Every valid flow competes
  assign request = pushValid;

  // Room when empty or when the held item leaves this cycle
  // Combinational path from popReady to pushReady
  assign canGrant = ~popValid | popReady;

  assign pushReady = grant & {flowMuxPkg::NumFlows{canGrant}};

  assign pushAccept = |(pushValid & pushReady);

  // Winner moves to the back of the LRU order only on a real transfer
  assign enablePriorityUpdate = pushAccept;

  // ------------------------------
  // Selection
  // ------------------------------

  // One-hot AND-OR mux plus grant encoder
  always_comb begin
    selData = '0;
    selIdx  = '0;
    for (int i = 0; i < flowMuxPkg::NumFlows; i++) begin
      selData = selData | (pushData[i] & {flowMuxPkg::DataWidth{grant[i]}});
      selIdx  = selIdx | (grant[i] ? flowMuxPkg::FlowIdxWidth'(i) : '0);
    end
  end

  always_comb begin
    nextItem.data    = selData;
    nextItem.flowIdx = selIdx;
  end

  // ------------------------------
  // Output register
  // ------------------------------

  // Refill wins over pop, a pop without refill empties the stage
  always_ff @(posedge clk) begin
    if (rst) begin
      popValid <= 1'b0;
    end else if (pushAccept) begin
      popValid <= 1'b1;
    end else if (popReady) begin
      popValid <= 1'b0;
    end
  end

  // Payload only moves on accept, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (pushAccept) begin
      popItem <= nextItem;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Stalled item stays put until the consumer takes it
  popStableA : assert property (
    @(posedge clk) disable iff (rst)
    (popValid && !popReady) |=> $stable(popItem)
  ) else $error("muxDatapath: popItem changed under back-pressure");

  // Producer contract, valid is held until accepted
  for (genvar i = 0; i < flowMuxPkg::NumFlows; i++) begin : gPushHold
    pushValidHoldA : assert property (
      @(posedge clk) disable iff (rst)
      (pushValid[i] && !pushReady[i]) |=> pushValid[i]
    ) else $error("muxDatapath: flow %0d dropped valid before accept", i);
  end

endmodule

//--- source/lruArbiter.sv
// LRU arbiter that keeps pairwise priority bits and grants one requesting flow
`timescale 1ns/1ps

module lruArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  flowMuxPkg::flowMask_t request,
  input  logic                  canGrant,
  output flowMuxPkg::flowMask_t grant,
  input  logic                  enablePriorityUpdate
);

  // ------------------------------
  // Priority state
  // ------------------------------

  // Bit set means the lower-indexed flow of the pair beats the higher one
  logic [flowMuxPkg::NumPairs-1:0] orderQ;
  logic [flowMuxPkg::NumPairs-1:0] orderD;

  // Full view of the order, row i says which flows i beats
  logic [flowMuxPkg::NumFlows-1:0][flowMuxPkg::NumFlows-1:0] beats;

  // Requesting flows that beat every other requester
  flowMuxPkg::flowMask_t winner;

  // Expand the triangle into the square matrix
  for (genvar i = 0; i < flowMuxPkg::NumFlows; i++) begin : gRow
    // A flow never loses to itself, so the diagonal does not mask the AND below
    assign beats[i][i] = 1'b1;

    for (genvar j = i + 1; j < flowMuxPkg::NumFlows; j++) begin : gPair
      assign beats[i][j] = orderQ[flowMuxPkg::pairIndex(i, j)];
      assign beats[j][i] = ~orderQ[flowMuxPkg::pairIndex(i, j)];

      // Granted flow drops below its partner, others keep their bit
      assign orderD[flowMuxPkg::pairIndex(i, j)] =
        grant[i] ? 1'b0 :
        grant[j] ? 1'b1 :
        orderQ[flowMuxPkg::pairIndex(i, j)];
    end
  end

  // ------------------------------
  // Grant
  // ------------------------------

  // Idle flows do not block anyone, hence the OR with ~request
  always_comb begin
    winner = '0;
    for (int i = 0; i < flowMuxPkg::NumFlows; i++) begin
      winner[i] = request[i] & (&(beats[i] | ~request));
    end
  end

  // No grant while the output register cannot take a word
  assign grant = winner & {flowMuxPkg::NumFlows{canGrant}};

  // ------------------------------
  // Order update
  // ------------------------------

  // Reset order is flow 0 first, then 1, 2, with 3 last
  always_ff @(posedge clk) begin
    if (rst) begin
      orderQ <= '1;
    end else if (enablePriorityUpdate) begin
      orderQ <= orderD;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Total order on the flows leaves at most one winner
  grantOneHotA : assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  ) else $error("lruArbiter: grant %b is not one-hot", grant);

  // A cyclic order would leave requesters with room but no winner
  grantWhenRequestA : assert property (
    @(posedge clk) disable iff (rst)
    (canGrant && (request != '0)) |-> (grant != '0)
  ) else $error("lruArbiter: request %b with room but no grant", request);

  // Datapath only accepts a word that this arbiter granted
  updateNeedsGrantA : assert property (
    @(posedge clk) disable iff (rst)
    enablePriorityUpdate |-> (grant != '0)
  ) else $error("lruArbiter: priority update without a grant");

endmodule

//--- source/flowMuxPkg.sv
// Flow mux package with the shared sizes, masks and pop item layout
package flowMuxPkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  // Producer flows merged into the single consumer flow
  localparam int NumFlows = 4;

  // Payload word width
  localparam int DataWidth = 16;

  // Source flow index width
  localparam int FlowIdxWidth = $clog2(NumFlows);

  // One order bit per unordered pair of flows
  localparam int NumPairs = NumFlows * (NumFlows - 1) / 2;

  // ------------------------------
  // Types
  // ------------------------------

  // One bit per flow, for valid, ready, request and grant
  typedef logic [NumFlows-1:0] flowMask_t;

  // Item presented on the pop side
  typedef struct packed {
    logic [DataWidth-1:0]    data;     // Payload word
    logic [FlowIdxWidth-1:0] flowIdx;  // Flow the word came from
  } popItem_t;

  // Slot of pair (lo, hi) in the triangular order vector, lo < hi
  // Row lo starts after all earlier rows, which hold NumFlows-1, NumFlows-2, ... bits
  function automatic int pairIndex(int lo, int hi);
    int rowBase;
    rowBase = lo * NumFlows - (lo * (lo + 1)) / 2;
    return rowBase + (hi - lo - 1);
  endfunction

endpackage
